// ==== design/dramCtrl_consts.svh ====
`ifndef DRAMCTRL_CONSTS_SVH
`define DRAMCTRL_CONSTS_SVH

// AXI field widths
`define AXI_ID_BITS 8
`define AXI_ADDR_BITS 32
`define AXI_LEN_BITS 4
`define AXI_DATA_BITS 32
`define AXI_STRB_BITS 4

// Row is addr[22:12], column is addr[11:2]
`define DRAM_ROW_BITS 11
`define DRAM_COL_BITS 10

// Phase lengths in clock cycles
`define DRAM_ROW_WAIT 5
`define DRAM_COL_CYCLE 7
`define DRAM_PRE_WAIT 5

// Wide enough for the longest phase above
`define DRAM_WAIT_BITS 3

`endif

// ==== design/dramCtrlPkg.sv ====
`include "dramCtrl_consts.svh"

package dramCtrlPkg;

	// One burst as accepted from AW or AR
	typedef struct packed {
		logic [`AXI_ID_BITS-1:0] id;
		logic [`AXI_ADDR_BITS-1:0] addr;
		logic [`AXI_LEN_BITS-1:0] len;
		logic isWrite;
	} burstReq_t;

	// Travels with each column read
	typedef struct packed {
		logic [`AXI_ID_BITS-1:0] id;
		logic last;
	} readTag_t;

	// One R beat
	typedef struct packed {
		logic [`AXI_DATA_BITS-1:0] data;
		logic [`AXI_ID_BITS-1:0] id;
		logic last;
	} readBeat_t;

	// Command on the DRAM pins this cycle
	typedef enum logic [2:0] {
		opIdle,
		opActivate,
		opRead,
		opWrite,
		opPrecharge
	} dramOp_t;

	typedef enum logic [2:0] {
		sIdle,
		sActivate,
		sColumn,
		sWaitBeat,
		sRespond,
		sPrecharge
	} seqState_t;

endpackage

// ==== design/axiRequestStage.sv ====
`timescale 1ns/1ps
`include "dramCtrl_consts.svh"

module axiRequestStage (
	input  logic clk,
	input  logic rst,

	input  logic [`AXI_ID_BITS-1:0] awId,
	input  logic [`AXI_ADDR_BITS-1:0] awAddr,
	input  logic [`AXI_LEN_BITS-1:0] awLen,
	input  logic awValid,
	output logic awReady,

	input  logic [`AXI_ID_BITS-1:0] arId,
	input  logic [`AXI_ADDR_BITS-1:0] arAddr,
	input  logic [`AXI_LEN_BITS-1:0] arLen,
	input  logic arValid,
	output logic arReady,

	output dramCtrlPkg::burstReq_t burstReq,
	output logic reqValid,
	input  logic reqReady
);

	logic held;
	logic awFire;
	logic arFire;
	logic grantOpen;

	assign awFire = awValid && awReady;
	assign arFire = arValid && arReady;

	// No new grant while a burst is held or a grant is still pending
	assign grantOpen = !held && !awReady && !arReady;

	always_ff @(posedge clk) begin
		if (rst) begin
			awReady <= 1'b0;
			arReady <= 1'b0;
		end else begin
			awReady <= 1'b0;
			arReady <= 1'b0;
			if (grantOpen) begin
				// Writes win when both channels ask together
				if (awValid) begin
					awReady <= 1'b1;
				end else if (arValid) begin
					arReady <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			held <= 1'b0;
		end else if (awFire || arFire) begin
			held <= 1'b1;
		end else if (held && reqReady) begin
			held <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (awFire) begin
			burstReq.id <= awId;
			burstReq.addr <= awAddr;
			burstReq.len <= awLen;
			burstReq.isWrite <= 1'b1;
		end else if (arFire) begin
			burstReq.id <= arId;
			burstReq.addr <= arAddr;
			burstReq.len <= arLen;
			burstReq.isWrite <= 1'b0;
		end
	end

	assign reqValid = held;

endmodule

// ==== design/dramSequencer.sv ====
`timescale 1ns/1ps
`include "dramCtrl_consts.svh"

module dramSequencer (
	input  logic clk,
	input  logic rst,

	input  dramCtrlPkg::burstReq_t burstReq,
	input  logic reqValid,
	output logic reqReady,

	input  logic [`AXI_DATA_BITS-1:0] wData,
	input  logic [`AXI_STRB_BITS-1:0] wStrb,
	input  logic wValid,
	output logic wReady,

	output logic [`AXI_ID_BITS-1:0] bId,
	output logic bValid,
	input  logic bReady,

	output dramCtrlPkg::readTag_t readTag,
	output logic tagValid,
	input  logic beatDone,

	output logic rasN,
	output logic casN,
	output logic [`DRAM_ROW_BITS-1:0] a,
	output logic [`AXI_DATA_BITS-1:0] d,
	output logic [`AXI_STRB_BITS-1:0] weN
);

	localparam logic [`DRAM_WAIT_BITS-1:0] rowLast = `DRAM_WAIT_BITS'(`DRAM_ROW_WAIT - 1);
	localparam logic [`DRAM_WAIT_BITS-1:0] colLast = `DRAM_WAIT_BITS'(`DRAM_COL_CYCLE - 1);
	localparam logic [`DRAM_WAIT_BITS-1:0] preLast = `DRAM_WAIT_BITS'(`DRAM_PRE_WAIT - 1);

	dramCtrlPkg::seqState_t state;
	dramCtrlPkg::dramOp_t op;
	dramCtrlPkg::burstReq_t req;

	logic [`AXI_LEN_BITS-1:0] beatCnt;
	logic [`DRAM_WAIT_BITS-1:0] waitCnt;
	logic [`DRAM_ROW_BITS-1:0] openRow;
	logic burstEnd;
	logic beatSeen;

	logic [`AXI_ADDR_BITS-1:0] curAddr;
	logic [`AXI_ADDR_BITS-1:0] nextAddr;
	logic [`DRAM_ROW_BITS-1:0] curRow;
	logic [`DRAM_ROW_BITS-1:0] nextRow;
	logic [`DRAM_COL_BITS-1:0] curCol;
	logic lastBeat;
	logic colIssue;
	logic beatFinish;

	// Byte address of the current and the following beat
	assign curAddr = req.addr + `AXI_ADDR_BITS'({beatCnt, 2'b00});
	assign nextAddr = curAddr + `AXI_ADDR_BITS'(4);
	assign curRow = curAddr[`DRAM_COL_BITS+2 +: `DRAM_ROW_BITS];
	assign nextRow = nextAddr[`DRAM_COL_BITS+2 +: `DRAM_ROW_BITS];
	assign curCol = curAddr[2 +: `DRAM_COL_BITS];
	assign lastBeat = (beatCnt == req.len);

	// A write column waits at count zero for its W beat
	assign colIssue = (state == dramCtrlPkg::sColumn) && (waitCnt == '0) &&
		(!req.isWrite || wValid);

	assign beatFinish = ((state == dramCtrlPkg::sColumn) && (waitCnt == colLast) && req.isWrite) ||
		((state == dramCtrlPkg::sWaitBeat) && (beatSeen || beatDone));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= dramCtrlPkg::sIdle;
			waitCnt <= '0;
			beatCnt <= '0;
			burstEnd <= 1'b0;
		end else begin
			case (state)
				dramCtrlPkg::sIdle: begin
					if (reqValid) begin
						beatCnt <= '0;
						waitCnt <= '0;
						state <= dramCtrlPkg::sActivate;
					end
				end
				dramCtrlPkg::sActivate: begin
					if (waitCnt == rowLast) begin
						waitCnt <= '0;
						state <= dramCtrlPkg::sColumn;
					end else begin
						waitCnt <= waitCnt + 1'b1;
					end
				end
				dramCtrlPkg::sColumn: begin
					if (waitCnt == '0 && !colIssue) begin
						waitCnt <= '0;
					end else if (waitCnt == colLast) begin
						waitCnt <= '0;
						if (!req.isWrite) begin
							state <= dramCtrlPkg::sWaitBeat;
						end
					end else begin
						waitCnt <= waitCnt + 1'b1;
					end
				end
				dramCtrlPkg::sPrecharge: begin
					if (waitCnt == preLast) begin
						waitCnt <= '0;
						if (!burstEnd) begin
							state <= dramCtrlPkg::sActivate;
						end else if (req.isWrite) begin
							state <= dramCtrlPkg::sRespond;
						end else begin
							state <= dramCtrlPkg::sIdle;
						end
						burstEnd <= 1'b0;
					end else begin
						waitCnt <= waitCnt + 1'b1;
					end
				end
				dramCtrlPkg::sRespond: begin
					if (bReady) begin
						state <= dramCtrlPkg::sIdle;
					end
				end
				default: begin
					waitCnt <= '0;
				end
			endcase

			// Move to the next beat, closing the row if it changes
			if (beatFinish) begin
				if (lastBeat) begin
					burstEnd <= 1'b1;
					state <= dramCtrlPkg::sPrecharge;
				end else begin
					beatCnt <= beatCnt + 1'b1;
					if (nextRow != openRow) begin
						state <= dramCtrlPkg::sPrecharge;
					end else begin
						state <= dramCtrlPkg::sColumn;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			beatSeen <= 1'b0;
		end else if (op == dramCtrlPkg::opRead) begin
			beatSeen <= 1'b0;
		end else if (beatDone) begin
			beatSeen <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (state == dramCtrlPkg::sIdle && reqValid) begin
			req <= burstReq;
		end
		if (op == dramCtrlPkg::opActivate) begin
			openRow <= curRow;
		end
	end

	always_comb begin
		op = dramCtrlPkg::opIdle;
		case (state)
			dramCtrlPkg::sActivate: begin
				if (waitCnt == '0) begin
					op = dramCtrlPkg::opActivate;
				end
			end
			dramCtrlPkg::sColumn: begin
				if (colIssue) begin
					op = req.isWrite ? dramCtrlPkg::opWrite : dramCtrlPkg::opRead;
				end
			end
			dramCtrlPkg::sPrecharge: begin
				if (waitCnt == '0) begin
					op = dramCtrlPkg::opPrecharge;
				end
			end
			default: begin
				op = dramCtrlPkg::opIdle;
			end
		endcase
	end

	always_comb begin
		rasN = 1'b1;
		casN = 1'b1;
		case (op)
			dramCtrlPkg::opActivate,
			dramCtrlPkg::opPrecharge: begin
				rasN = 1'b0;
			end
			dramCtrlPkg::opRead,
			dramCtrlPkg::opWrite: begin
				casN = 1'b0;
			end
			default: begin
				rasN = 1'b1;
			end
		endcase
	end

	// Address held steady over each phase
	always_comb begin
		case (state)
			dramCtrlPkg::sActivate: a = curRow;
			dramCtrlPkg::sPrecharge: a = openRow;
			dramCtrlPkg::sColumn: a = {1'b0, curCol};
			default: a = '0;
		endcase
	end

	assign d = (op == dramCtrlPkg::opWrite) ? wData : '0;
	assign weN = (op == dramCtrlPkg::opWrite) ? ~wStrb : '1;

	assign reqReady = (state == dramCtrlPkg::sIdle);
	assign wReady = (state == dramCtrlPkg::sColumn) && (waitCnt == '0) && req.isWrite;
	assign bValid = (state == dramCtrlPkg::sRespond);
	assign bId = req.id;

	assign tagValid = (op == dramCtrlPkg::opRead);
	assign readTag.id = req.id;
	assign readTag.last = lastBeat;

endmodule

// ==== design/readReturnStage.sv ====
`timescale 1ns/1ps
`include "dramCtrl_consts.svh"

module readReturnStage (
	input  logic clk,
	input  logic rst,

	input  dramCtrlPkg::readTag_t readTag,
	input  logic tagValid,

	input  logic [`AXI_DATA_BITS-1:0] q,
	input  logic dramValid,

	output dramCtrlPkg::readBeat_t rBeat,
	output logic rValid,
	input  logic rReady,
	output logic beatDone
);

	dramCtrlPkg::readTag_t tagReg;
	logic tagPending;
	logic capture;

	// Only one read is ever in flight, so a single tag slot is enough
	assign capture = dramValid && tagPending;

	always_ff @(posedge clk) begin
		if (rst) begin
			tagPending <= 1'b0;
			rValid <= 1'b0;
		end else begin
			if (tagValid) begin
				tagPending <= 1'b1;
			end else if (capture) begin
				tagPending <= 1'b0;
			end
			if (capture) begin
				rValid <= 1'b1;
			end else if (rValid && rReady) begin
				rValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (tagValid) begin
			tagReg <= readTag;
		end
		if (capture) begin
			rBeat.data <= q;
			rBeat.id <= tagReg.id;
			rBeat.last <= tagReg.last;
		end
	end

	assign beatDone = rValid && rReady;

endmodule

// ==== design/dramSubsystem.sv ====
`timescale 1ns/1ps
`include "dramCtrl_consts.svh"

module dramSubsystem (
	input  logic clk,
	input  logic rst,

	input  logic [`AXI_ID_BITS-1:0] awId,
	input  logic [`AXI_ADDR_BITS-1:0] awAddr,
	input  logic [`AXI_LEN_BITS-1:0] awLen,
	input  logic awValid,
	output logic awReady,

	input  logic [`AXI_DATA_BITS-1:0] wData,
	input  logic [`AXI_STRB_BITS-1:0] wStrb,
	input  logic wValid,
	output logic wReady,

	output logic [`AXI_ID_BITS-1:0] bId,
	output logic [1:0] bResp,
	output logic bValid,
	input  logic bReady,

	input  logic [`AXI_ID_BITS-1:0] arId,
	input  logic [`AXI_ADDR_BITS-1:0] arAddr,
	input  logic [`AXI_LEN_BITS-1:0] arLen,
	input  logic arValid,
	output logic arReady,

	output logic [`AXI_ID_BITS-1:0] rId,
	output logic [`AXI_DATA_BITS-1:0] rData,
	output logic [1:0] rResp,
	output logic rLast,
	output logic rValid,
	input  logic rReady,

	input  logic [`AXI_DATA_BITS-1:0] q,
	input  logic dramValid,
	output logic csN,
	output logic rasN,
	output logic casN,
	output logic [`DRAM_ROW_BITS-1:0] a,
	output logic [`AXI_DATA_BITS-1:0] d,
	output logic [`AXI_STRB_BITS-1:0] weN
);

	dramCtrlPkg::burstReq_t burstReq;
	dramCtrlPkg::readTag_t readTag;
	dramCtrlPkg::readBeat_t rBeat;
	logic reqValid;
	logic reqReady;
	logic tagValid;
	logic beatDone;

	axiRequestStage requestStage (
		.clk(clk),
		.rst(rst),
		.awId(awId),
		.awAddr(awAddr),
		.awLen(awLen),
		.awValid(awValid),
		.awReady(awReady),
		.arId(arId),
		.arAddr(arAddr),
		.arLen(arLen),
		.arValid(arValid),
		.arReady(arReady),
		.burstReq(burstReq),
		.reqValid(reqValid),
		.reqReady(reqReady)
	);

	dramSequencer sequencer (
		.clk(clk),
		.rst(rst),
		.burstReq(burstReq),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.wData(wData),
		.wStrb(wStrb),
		.wValid(wValid),
		.wReady(wReady),
		.bId(bId),
		.bValid(bValid),
		.bReady(bReady),
		.readTag(readTag),
		.tagValid(tagValid),
		.beatDone(beatDone),
		.rasN(rasN),
		.casN(casN),
		.a(a),
		.d(d),
		.weN(weN)
	);

	readReturnStage returnStage (
		.clk(clk),
		.rst(rst),
		.readTag(readTag),
		.tagValid(tagValid),
		.q(q),
		.dramValid(dramValid),
		.rBeat(rBeat),
		.rValid(rValid),
		.rReady(rReady),
		.beatDone(beatDone)
	);

	assign rId = rBeat.id;
	assign rData = rBeat.data;
	assign rLast = rBeat.last;

	// Always OKAY
	assign rResp = 2'b00;
	assign bResp = 2'b00;

	// Single rank, always selected
	assign csN = 1'b0;

endmodule

// ==== bench/dramChecker.sv ====
`timescale 1ns/1ps
`include "dramCtrl_consts.svh"

module dramChecker (
	input  logic clk,
	input  logic rst,
	input  logic [`AXI_ID_BITS-1:0] awId,
	input  logic [`AXI_ADDR_BITS-1:0] awAddr,
	input  logic [`AXI_LEN_BITS-1:0] awLen,
	input  logic awValid,
	input  logic awReady,
	input  logic [`AXI_DATA_BITS-1:0] wData,
	input  logic [`AXI_STRB_BITS-1:0] wStrb,
	input  logic wValid,
	input  logic wReady,
	input  logic [`AXI_ID_BITS-1:0] bId,
	input  logic [1:0] bResp,
	input  logic bValid,
	input  logic bReady,
	input  logic [`AXI_ID_BITS-1:0] arId,
	input  logic [`AXI_ADDR_BITS-1:0] arAddr,
	input  logic [`AXI_LEN_BITS-1:0] arLen,
	input  logic arValid,
	input  logic arReady,
	input  logic [`AXI_ID_BITS-1:0] rId,
	input  logic [`AXI_DATA_BITS-1:0] rData,
	input  logic [1:0] rResp,
	input  logic rLast,
	input  logic rValid,
	input  logic rReady,
	input  logic csN,
	input  logic rasN,
	input  logic casN,
	output int errCount,
	output int rBeatCount,
	output int bRespCount
);

	// Reference memory, one entry per written byte
	logic [7:0] refMem [int];
	logic [`AXI_ID_BITS-1:0] wrId;
	logic [`AXI_ID_BITS-1:0] rdId;
	logic [`AXI_ADDR_BITS-1:0] wrAddr;
	logic [`AXI_ADDR_BITS-1:0] rdAddr;
	logic [`AXI_LEN_BITS-1:0] wrLen;
	logic [`AXI_LEN_BITS-1:0] rdLen;
	int wBeat;
	int rBeat;
	logic started;
	logic bOwed;
	logic rdOpen;

	// Content of a word that was never written
	function automatic logic [31:0] fillWord(input logic [31:0] wordAddr);
		return (wordAddr * 32'h9e3779b1) ^ 32'h5a3c96e1;
	endfunction

	function automatic logic [31:0] expectedWord(input logic [31:0] byteAddr);
		logic [31:0] base;
		logic [31:0] word;
		int idx;
		base = byteAddr & 32'h007f_fffc;
		word = fillWord(base >> 2);
		for (int i = 0; i < 4; i++) begin
			idx = int'(base) + i;
			if (refMem.exists(idx)) begin
				word[8*i +: 8] = refMem[idx];
			end
		end
		return word;
	endfunction

	always @(posedge clk) begin
		logic [31:0] addr;
		logic [31:0] exp;
		if (rst) begin
			errCount = 0;
			rBeatCount = 0;
			bRespCount = 0;
			started = 1'b0;
			wBeat = 0;
			rBeat = 0;
			bOwed = 1'b0;
			rdOpen = 1'b0;
		end else begin
			if (awValid || arValid) begin
				started = 1'b1;
			end
			// Quiet bus until the first request
			if (!started) begin
				if (awReady || arReady || wReady || rValid || bValid) begin
					$display("ERR idle outputs awReady=%h arReady=%h wReady=%h rValid=%h bValid=%h",
						awReady, arReady, wReady, rValid, bValid);
					errCount++;
				end
				if (!rasN || !casN) begin
					$display("ERR idle pins rasN=%h casN=%h", rasN, casN);
					errCount++;
				end
			end
			if (csN !== 1'b0) begin
				$display("ERR csN exp=%h got=%h", 1'b0, csN);
				errCount++;
			end
			if (arReady && awValid) begin
				$display("Read address accepted while a write address was still waiting");
				errCount++;
			end
			if (awValid && awReady) begin
				wrId = awId;
				wrAddr = awAddr;
				wrLen = awLen;
				wBeat = 0;
				bOwed = 1'b1;
			end
			if (wValid && wReady) begin
				if (wBeat > int'(wrLen)) begin
					$display("Write beat accepted beyond the end of the burst");
					errCount++;
				end
				addr = (wrAddr + 32'(wBeat) * 32'd4) & 32'h007f_fffc;
				for (int i = 0; i < 4; i++) begin
					if (wStrb[i]) begin
						refMem[int'(addr) + i] = wData[8*i +: 8];
					end
				end
				wBeat++;
			end
			if (bValid && bReady) begin
				if (!bOwed) begin
					$display("Write response with no write burst open");
					errCount++;
				end
				if (bId != wrId) begin
					$display("ERR bId exp=%h got=%h", wrId, bId);
					errCount++;
				end
				if (bResp != 2'b00) begin
					$display("ERR bResp exp=%h got=%h", 2'b00, bResp);
					errCount++;
				end
				if (wBeat != int'(wrLen) + 1) begin
					$display("Write response after %0d beats of a %0d beat burst",
						wBeat, int'(wrLen) + 1);
					errCount++;
				end
				bOwed = 1'b0;
				bRespCount++;
			end
			if (arValid && arReady) begin
				rdId = arId;
				rdAddr = arAddr;
				rdLen = arLen;
				rBeat = 0;
				rdOpen = 1'b1;
			end
			if (rValid && rReady) begin
				exp = expectedWord(rdAddr + 32'(rBeat) * 32'd4);
				if (!rdOpen) begin
					$display("Read beat with no read burst open");
					errCount++;
				end
				if (rBeat > int'(rdLen)) begin
					$display("Read beat returned beyond the end of the burst");
					errCount++;
				end
				if (rData != exp) begin
					$display("ERR rData beat=%h exp=%h got=%h", rBeat, exp, rData);
					errCount++;
				end
				if (rId != rdId) begin
					$display("ERR rId exp=%h got=%h", rdId, rId);
					errCount++;
				end
				if (rResp != 2'b00) begin
					$display("ERR rResp exp=%h got=%h", 2'b00, rResp);
					errCount++;
				end
				if (rLast != (rBeat == int'(rdLen))) begin
					$display("ERR rLast beat=%h exp=%h got=%h", rBeat, rBeat == int'(rdLen), rLast);
					errCount++;
				end
				if (rLast) begin
					rdOpen = 1'b0;
				end
				rBeat++;
				rBeatCount++;
			end
		end
	end

endmodule

// ==== bench/dramSubsystemTb.sv ====
`timescale 1ns/1ps
`include "dramCtrl_consts.svh"

module dramSubsystemTb;

	localparam int timeoutCycles = 2000;
	localparam int numBursts = 40;
	localparam logic [2:0] readLatency = 3'd3;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic [`AXI_ID_BITS-1:0] awId = '0;
	logic [`AXI_ADDR_BITS-1:0] awAddr = '0;
	logic [`AXI_LEN_BITS-1:0] awLen = '0;
	logic awValid = 1'b0;
	logic awReady;
	logic [`AXI_DATA_BITS-1:0] wData = '0;
	logic [`AXI_STRB_BITS-1:0] wStrb = '0;
	logic wValid = 1'b0;
	logic wReady;
	logic [`AXI_ID_BITS-1:0] bId;
	logic [1:0] bResp;
	logic bValid;
	logic bReady = 1'b0;
	logic [`AXI_ID_BITS-1:0] arId = '0;
	logic [`AXI_ADDR_BITS-1:0] arAddr = '0;
	logic [`AXI_LEN_BITS-1:0] arLen = '0;
	logic arValid = 1'b0;
	logic arReady;
	logic [`AXI_ID_BITS-1:0] rId;
	logic [`AXI_DATA_BITS-1:0] rData;
	logic [1:0] rResp;
	logic rLast;
	logic rValid;
	logic rReady = 1'b0;
	logic [`AXI_DATA_BITS-1:0] q = '0;
	logic dramValid = 1'b0;
	logic csN;
	logic rasN;
	logic casN;
	logic [`DRAM_ROW_BITS-1:0] a;
	logic [`AXI_DATA_BITS-1:0] d;
	logic [`AXI_STRB_BITS-1:0] weN;

	int checkErrs;
	int rBeatCount;
	int bRespCount;
	int timeoutCount = 0;
	logic timedOut = 1'b0;

	// DRAM model state
	logic [31:0] dramMem [int];
	logic rowOpen = 1'b0;
	logic [`DRAM_ROW_BITS-1:0] openRow = '0;
	logic [2:0] readCnt = '0;
	logic [31:0] readWord = '0;

	dramSubsystem uut (
		.clk(clk), .rst(rst),
		.awId(awId), .awAddr(awAddr), .awLen(awLen), .awValid(awValid), .awReady(awReady),
		.wData(wData), .wStrb(wStrb), .wValid(wValid), .wReady(wReady),
		.bId(bId), .bResp(bResp), .bValid(bValid), .bReady(bReady),
		.arId(arId), .arAddr(arAddr), .arLen(arLen), .arValid(arValid), .arReady(arReady),
		.rId(rId), .rData(rData), .rResp(rResp), .rLast(rLast), .rValid(rValid), .rReady(rReady),
		.q(q), .dramValid(dramValid), .csN(csN), .rasN(rasN), .casN(casN),
		.a(a), .d(d), .weN(weN)
	);

	dramChecker axiCheck (
		.clk(clk), .rst(rst),
		.awId(awId), .awAddr(awAddr), .awLen(awLen), .awValid(awValid), .awReady(awReady),
		.wData(wData), .wStrb(wStrb), .wValid(wValid), .wReady(wReady),
		.bId(bId), .bResp(bResp), .bValid(bValid), .bReady(bReady),
		.arId(arId), .arAddr(arAddr), .arLen(arLen), .arValid(arValid), .arReady(arReady),
		.rId(rId), .rData(rData), .rResp(rResp), .rLast(rLast), .rValid(rValid), .rReady(rReady),
		.csN(csN), .rasN(rasN), .casN(casN),
		.errCount(checkErrs), .rBeatCount(rBeatCount), .bRespCount(bRespCount)
	);

	initial begin
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] fillWord(input logic [31:0] wordAddr);
		return (wordAddr * 32'h9e3779b1) ^ 32'h5a3c96e1;
	endfunction

	// Activate and precharge share the same pin pattern, so track the open row
	always @(posedge clk) begin
		logic [31:0] word;
		int idx;
		if (rst) begin
			rowOpen <= 1'b0;
			readCnt <= '0;
			dramValid <= 1'b0;
		end else begin
			dramValid <= (readCnt == 3'd1);
			q <= readWord;
			if (readCnt != 3'd0) begin
				readCnt <= readCnt - 3'd1;
			end
			if (!rasN && casN) begin
				if (!rowOpen) begin
					rowOpen <= 1'b1;
					openRow <= a;
				end else begin
					rowOpen <= 1'b0;
				end
			end
			if (!casN) begin
				idx = int'({openRow, a[`DRAM_COL_BITS-1:0]});
				word = dramMem.exists(idx) ? dramMem[idx] : fillWord(32'(idx));
				if (weN != 4'hf) begin
					for (int i = 0; i < 4; i++) begin
						if (!weN[i]) begin
							word[8*i +: 8] = d[8*i +: 8];
						end
					end
					dramMem[idx] = word;
				end else begin
					readWord <= word;
					readCnt <= readLatency;
				end
			end
		end
	end

	function automatic void reportTimeout(input string what);
		$display("Timeout while waiting for %s", what);
		timeoutCount++;
		timedOut = 1'b1;
	endfunction

	// Row near its end in about one burst of three
	function automatic logic [31:0] pickAddr();
		logic [`DRAM_ROW_BITS-1:0] row;
		logic [`DRAM_COL_BITS-1:0] col;
		row = `DRAM_ROW_BITS'($urandom);
		if ($urandom % 3 == 0) begin
			col = `DRAM_COL_BITS'(1023 - ($urandom % 8));
		end else begin
			col = `DRAM_COL_BITS'($urandom);
		end
		return {9'b0, row, col, 2'b00};
	endfunction

	task automatic waitAwHandshake();
		int n;
		logic done;
		n = 0;
		done = 1'b0;
		while (!done && !timedOut) begin
			@(posedge clk);
			if (awValid && awReady) begin
				awValid <= 1'b0;
				done = 1'b1;
			end else begin
				n++;
				if (n >= timeoutCycles) reportTimeout("AWREADY");
			end
		end
	endtask

	task automatic waitArHandshake();
		int n;
		logic done;
		n = 0;
		done = 1'b0;
		while (!done && !timedOut) begin
			@(posedge clk);
			if (arValid && arReady) begin
				arValid <= 1'b0;
				done = 1'b1;
			end else begin
				n++;
				if (n >= timeoutCycles) reportTimeout("ARREADY");
			end
		end
	endtask

	task automatic sendWriteBeats(input logic [`AXI_LEN_BITS-1:0] len);
		int n;
		logic done;
		for (int i = 0; i <= int'(len) && !timedOut; i++) begin
			wData <= $urandom;
			wStrb <= `AXI_STRB_BITS'($urandom);
			wValid <= 1'b1;
			n = 0;
			done = 1'b0;
			while (!done && !timedOut) begin
				@(posedge clk);
				if (wValid && wReady) begin
					done = 1'b1;
				end else begin
					n++;
					if (n >= timeoutCycles) reportTimeout("WREADY");
				end
			end
		end
		wValid <= 1'b0;
	endtask

	task automatic waitWriteResponse();
		int n;
		logic done;
		n = 0;
		done = 1'b0;
		while (!done && !timedOut) begin
			@(posedge clk);
			if (bValid && bReady) begin
				bReady <= 1'b0;
				done = 1'b1;
			end else begin
				bReady <= ($urandom % 3 != 0);
				n++;
				if (n >= timeoutCycles) reportTimeout("BVALID");
			end
		end
	endtask

	task automatic collectReadBeats();
		int n;
		logic done;
		n = 0;
		done = 1'b0;
		while (!done && !timedOut) begin
			@(posedge clk);
			if (rValid && rReady && rLast) begin
				rReady <= 1'b0;
				done = 1'b1;
			end else begin
				rReady <= ($urandom % 4 != 0);
				n++;
				if (n >= timeoutCycles) reportTimeout("the last R beat");
			end
		end
	endtask

	initial begin
		logic [31:0] addr;
		logic [31:0] lastAddr;
		logic [`AXI_LEN_BITS-1:0] len;
		logic [`AXI_LEN_BITS-1:0] lastLen;
		int kind;
		void'($urandom(32'h55cd));
		lastAddr = 32'h0000_0ff0;
		lastLen = 4'd7;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		// A few idle cycles to observe the reset state
		repeat (5) @(posedge clk);
		for (int n = 0; n < numBursts && !timedOut; n++) begin
			kind = int'($urandom % 8);
			addr = pickAddr();
			len = `AXI_LEN_BITS'($urandom);
			if (kind == 0) begin
				// Write and read raised together
				awId <= `AXI_ID_BITS'($urandom);
				awAddr <= addr;
				awLen <= len;
				awValid <= 1'b1;
				arId <= `AXI_ID_BITS'($urandom);
				arAddr <= addr;
				arLen <= len;
				arValid <= 1'b1;
				waitAwHandshake();
				// AR can be taken while the write is still running
				fork
					begin
						sendWriteBeats(len);
						waitWriteResponse();
					end
					waitArHandshake();
				join
				collectReadBeats();
			end else if (kind < 4) begin
				awId <= `AXI_ID_BITS'($urandom);
				awAddr <= addr;
				awLen <= len;
				awValid <= 1'b1;
				lastAddr = addr;
				lastLen = len;
				waitAwHandshake();
				sendWriteBeats(len);
				waitWriteResponse();
			end else begin
				if ($urandom % 2 == 0) begin
					addr = lastAddr;
					len = lastLen;
				end
				arId <= `AXI_ID_BITS'($urandom);
				arAddr <= addr;
				arLen <= len;
				arValid <= 1'b1;
				waitArHandshake();
				collectReadBeats();
			end
			@(posedge clk);
		end
		repeat (3) @(posedge clk);
		$display("Errors: %0d check, %0d timeout; %0d R beats, %0d B responses",
			checkErrs, timeoutCount, rBeatCount, bRespCount);
		if (checkErrs == 0 && timeoutCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+design
design/dramCtrlPkg.sv
design/axiRequestStage.sv
design/dramSequencer.sv
design/readReturnStage.sv
design/dramSubsystem.sv
bench/dramChecker.sv
bench/dramSubsystemTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= dramSubsystemTb
OBJ_DIR ?= obj_dir
LOG ?= sim.log
FILELIST ?= build.f
VFLAGS ?= --binary --timing

SOURCES := $(wildcard design/*.sv design/*.svh bench/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)

check: run
	@if grep -q "\*\*\* TEST FAILED \*\*\*" $(LOG); then exit 1; fi
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
